//--- logic/busPkg.sv
package busPkg;

  typedef logic [31:0] addrT;
  typedef logic [31:0] dataT;
  typedef logic [3:0]  strbT;
  typedef logic [1:0]  respT;

  // SRAM word index from address bits 9:2
  typedef logic [7:0]  sramIndexT;

  localparam respT respOkay = 2'b00;

  // the one UART register address
  localparam addrT uartAddr = 32'h1000_0000;

  localparam int sramDepth = 256;

  // router ownership of the current transaction
  typedef enum logic [1:0] {
    routeIdle,
    busyA,
    busyB
  } routeStateT;

  // per-direction device handshake state
  typedef enum logic {
    devIdle,
    respond
  } devStateT;

endpackage

//--- logic/readRouter.sv
`timescale 1ns/1ps

module readRouter (
  input  logic          clk,
  input  logic          rst,
  input  logic          arvalidA_i,
  input  logic          arvalidB_i,
  input  busPkg::addrT  araddrA_i,
  input  busPkg::addrT  araddrB_i,
  input  logic          rreadyA_i,
  input  logic          rreadyB_i,
  input  logic          uartArready_i,
  input  logic          uartRvalid_i,
  input  busPkg::dataT  uartRdata_i,
  input  busPkg::respT  uartRresp_i,
  input  logic          sramArready_i,
  input  logic          sramRvalid_i,
  input  busPkg::dataT  sramRdata_i,
  input  busPkg::respT  sramRresp_i,
  output logic          arreadyA_o,
  output logic          arreadyB_o,
  output logic          rvalidA_o,
  output logic          rvalidB_o,
  output busPkg::dataT  rdataA_o,
  output busPkg::dataT  rdataB_o,
  output busPkg::respT  rrespA_o,
  output busPkg::respT  rrespB_o,
  output logic          uartArvalid_o,
  output busPkg::addrT  uartAraddr_o,
  output logic          uartRready_o,
  output logic          sramArvalid_o,
  output busPkg::addrT  sramAraddr_o,
  output logic          sramRready_o
);
  import busPkg::*;

  routeStateT state;
  // set when the owned transaction went to the UART
  logic       devSel;
  logic       isIdle;
  logic       grantA;
  logic       reqValid;
  addrT       reqAddr;
  logic       toUart;
  logic       devArready;
  logic       selRvalid;
  dataT       selRdata;
  respT       selRresp;
  logic       ownerRready;

  assign isIdle = (state == routeIdle);

  // fixed priority with A before B
  assign grantA     = arvalidA_i;
  assign reqValid   = arvalidA_i | arvalidB_i;
  assign reqAddr    = grantA ? araddrA_i : araddrB_i;
  assign toUart     = (reqAddr == uartAddr);
  assign devArready = toUart ? uartArready_i : sramArready_i;

  assign uartArvalid_o = isIdle && reqValid && toUart;
  assign sramArvalid_o = isIdle && reqValid && !toUart;
  assign uartAraddr_o  = reqAddr;
  assign sramAraddr_o  = reqAddr;

  // no new grants while a response is outstanding
  assign arreadyA_o = isIdle && grantA && devArready;
  assign arreadyB_o = isIdle && !grantA && arvalidB_i && devArready;

  assign selRvalid   = devSel ? uartRvalid_i : sramRvalid_i;
  assign selRdata    = devSel ? uartRdata_i : sramRdata_i;
  assign selRresp    = devSel ? uartRresp_i : sramRresp_i;
  assign ownerRready = (state == busyA) ? rreadyA_i : rreadyB_i;

  assign uartRready_o = !isIdle && devSel && ownerRready;
  assign sramRready_o = !isIdle && !devSel && ownerRready;

  // response goes back to the owner only
  assign rvalidA_o = (state == busyA) && selRvalid;
  assign rvalidB_o = (state == busyB) && selRvalid;
  assign rdataA_o  = (state == busyA) ? selRdata : '0;
  assign rdataB_o  = (state == busyB) ? selRdata : '0;
  assign rrespA_o  = (state == busyA) ? selRresp : respOkay;
  assign rrespB_o  = (state == busyB) ? selRresp : respOkay;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= routeIdle;
      devSel <= 1'b0;
    end else begin
      case (state)
        routeIdle: begin
          if (reqValid && devArready) begin
            state  <= grantA ? busyA : busyB;
            devSel <= toUart;
          end
        end
        default: begin
          if (selRvalid && ownerRready) begin
            state <= routeIdle;
          end
        end
      endcase
    end
  end

endmodule

//--- logic/writeRouter.sv
`timescale 1ns/1ps

module writeRouter (
  input  logic          clk,
  input  logic          rst,
  input  logic          awvalidA_i,
  input  logic          awvalidB_i,
  input  busPkg::addrT  awaddrA_i,
  input  busPkg::addrT  awaddrB_i,
  input  logic          wvalidA_i,
  input  logic          wvalidB_i,
  input  busPkg::dataT  wdataA_i,
  input  busPkg::dataT  wdataB_i,
  input  busPkg::strbT  wstrbA_i,
  input  busPkg::strbT  wstrbB_i,
  input  logic          breadyA_i,
  input  logic          breadyB_i,
  input  logic          uartAwready_i,
  input  logic          uartWready_i,
  input  logic          uartBvalid_i,
  input  busPkg::respT  uartBresp_i,
  input  logic          sramAwready_i,
  input  logic          sramWready_i,
  input  logic          sramBvalid_i,
  input  busPkg::respT  sramBresp_i,
  output logic          awreadyA_o,
  output logic          awreadyB_o,
  output logic          wreadyA_o,
  output logic          wreadyB_o,
  output logic          bvalidA_o,
  output logic          bvalidB_o,
  output busPkg::respT  brespA_o,
  output busPkg::respT  brespB_o,
  output logic          uartAwvalid_o,
  output busPkg::addrT  uartAwaddr_o,
  output logic          uartWvalid_o,
  output busPkg::dataT  uartWdata_o,
  output busPkg::strbT  uartWstrb_o,
  output logic          uartBready_o,
  output logic          sramAwvalid_o,
  output busPkg::addrT  sramAwaddr_o,
  output logic          sramWvalid_o,
  output busPkg::dataT  sramWdata_o,
  output busPkg::strbT  sramWstrb_o,
  output logic          sramBready_o
);
  import busPkg::*;

  routeStateT state;
  logic       devSel;
  logic       isIdle;
  logic       reqA;
  logic       reqB;
  logic       grantA;
  logic       reqValid;
  addrT       reqAddr;
  dataT       reqData;
  strbT       reqStrb;
  logic       toUart;
  logic       devAwready;
  logic       devWready;
  logic       selBvalid;
  respT       selBresp;
  logic       ownerBready;

  assign isIdle = (state == routeIdle);

  // a master only competes once address and data are both presented
  assign reqA     = awvalidA_i && wvalidA_i;
  assign reqB     = awvalidB_i && wvalidB_i;
  assign grantA   = reqA;
  assign reqValid = reqA | reqB;

  assign reqAddr = grantA ? awaddrA_i : awaddrB_i;
  assign reqData = grantA ? wdataA_i : wdataB_i;
  assign reqStrb = grantA ? wstrbA_i : wstrbB_i;
  assign toUart  = (reqAddr == uartAddr);

  assign devAwready = toUart ? uartAwready_i : sramAwready_i;
  assign devWready  = toUart ? uartWready_i : sramWready_i;

  assign uartAwvalid_o = isIdle && reqValid && toUart;
  assign uartWvalid_o  = isIdle && reqValid && toUart;
  assign sramAwvalid_o = isIdle && reqValid && !toUart;
  assign sramWvalid_o  = isIdle && reqValid && !toUart;
  assign uartAwaddr_o  = reqAddr;
  assign sramAwaddr_o  = reqAddr;
  assign uartWdata_o   = reqData;
  assign sramWdata_o   = reqData;
  assign uartWstrb_o   = reqStrb;
  assign sramWstrb_o   = reqStrb;

  assign awreadyA_o = isIdle && grantA && devAwready;
  assign wreadyA_o  = isIdle && grantA && devWready;
  assign awreadyB_o = isIdle && !grantA && reqB && devAwready;
  assign wreadyB_o  = isIdle && !grantA && reqB && devWready;

  assign selBvalid   = devSel ? uartBvalid_i : sramBvalid_i;
  assign selBresp    = devSel ? uartBresp_i : sramBresp_i;
  assign ownerBready = (state == busyA) ? breadyA_i : breadyB_i;

  assign uartBready_o = !isIdle && devSel && ownerBready;
  assign sramBready_o = !isIdle && !devSel && ownerBready;

  assign bvalidA_o = (state == busyA) && selBvalid;
  assign bvalidB_o = (state == busyB) && selBvalid;
  assign brespA_o  = (state == busyA) ? selBresp : respOkay;
  assign brespB_o  = (state == busyB) ? selBresp : respOkay;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= routeIdle;
      devSel <= 1'b0;
    end else begin
      case (state)
        routeIdle: begin
          // device takes address and data in the same cycle
          if (reqValid && devAwready && devWready) begin
            state  <= grantA ? busyA : busyB;
            devSel <= toUart;
          end
        end
        default: begin
          if (selBvalid && ownerBready) begin
            state <= routeIdle;
          end
        end
      endcase
    end
  end

endmodule

//--- logic/uartDevice.sv
`timescale 1ns/1ps

module uartDevice (
  input  logic          clk,
  input  logic          rst,
  input  logic          arvalid_i,
  input  busPkg::addrT  araddr_i,
  input  logic          rready_i,
  input  logic          awvalid_i,
  input  busPkg::addrT  awaddr_i,
  input  logic          wvalid_i,
  input  busPkg::dataT  wdata_i,
  input  busPkg::strbT  wstrb_i,
  input  logic          bready_i,
  output logic          arready_o,
  output logic          rvalid_o,
  output busPkg::dataT  rdata_o,
  output busPkg::respT  rresp_o,
  output logic          awready_o,
  output logic          wready_o,
  output logic          bvalid_o,
  output busPkg::respT  bresp_o,
  output logic [7:0]    txByte_o,
  output logic          txValid_o
);
  import busPkg::*;

  devStateT rState;
  devStateT wState;
  dataT     sentCount;
  logic     rAccept;
  logic     wAccept;
  logic     txFire;

  assign arready_o = (rState == devIdle);
  assign awready_o = (wState == devIdle);
  assign wready_o  = (wState == devIdle);
  assign rvalid_o  = (rState == respond);
  assign bvalid_o  = (wState == respond);
  assign rresp_o   = respOkay;
  assign bresp_o   = respOkay;

  assign rAccept = arvalid_i && arready_o;
  assign wAccept = awvalid_i && wvalid_i && awready_o;
  // byte lane 0 carries the character
  assign txFire  = wAccept && wstrb_i[0] && (awaddr_i == uartAddr);

  always_ff @(posedge clk) begin
    if (rst) begin
      rState    <= devIdle;
      wState    <= devIdle;
      txValid_o <= 1'b0;
      sentCount <= '0;
    end else begin
      if (rAccept) begin
        rState <= respond;
      end else if (rvalid_o && rready_i) begin
        rState <= devIdle;
      end
      if (wAccept) begin
        wState <= respond;
      end else if (bvalid_o && bready_i) begin
        wState <= devIdle;
      end
      txValid_o <= txFire;
      if (txFire) begin
        sentCount <= sentCount + 1'b1;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (rAccept) begin
      rdata_o <= (araddr_i == uartAddr) ? sentCount : '0;
    end
    if (txFire) begin
      txByte_o <= wdata_i[7:0];
    end
  end

endmodule

//--- logic/sramDevice.sv
`timescale 1ns/1ps

module sramDevice (
  input  logic          clk,
  input  logic          rst,
  input  logic          arvalid_i,
  input  busPkg::addrT  araddr_i,
  input  logic          rready_i,
  input  logic          awvalid_i,
  input  busPkg::addrT  awaddr_i,
  input  logic          wvalid_i,
  input  busPkg::dataT  wdata_i,
  input  busPkg::strbT  wstrb_i,
  input  logic          bready_i,
  output logic          arready_o,
  output logic          rvalid_o,
  output busPkg::dataT  rdata_o,
  output busPkg::respT  rresp_o,
  output logic          awready_o,
  output logic          wready_o,
  output logic          bvalid_o,
  output busPkg::respT  bresp_o
);
  import busPkg::*;

  dataT      mem [sramDepth];
  devStateT  rState;
  devStateT  wState;
  sramIndexT rIndex;
  sramIndexT wIndex;
  logic      rAccept;
  logic      wAccept;

  assign arready_o = (rState == devIdle);
  assign awready_o = (wState == devIdle);
  assign wready_o  = (wState == devIdle);
  assign rvalid_o  = (rState == respond);
  assign bvalid_o  = (wState == respond);
  assign rresp_o   = respOkay;
  assign bresp_o   = respOkay;

  // word addressed so upper address bits alias
  assign rIndex = araddr_i[9:2];
  assign wIndex = awaddr_i[9:2];

  assign rAccept = arvalid_i && arready_o;
  assign wAccept = awvalid_i && wvalid_i && awready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      rState <= devIdle;
      wState <= devIdle;
    end else begin
      if (rAccept) begin
        rState <= respond;
      end else if (rvalid_o && rready_i) begin
        rState <= devIdle;
      end
      if (wAccept) begin
        wState <= respond;
      end else if (bvalid_o && bready_i) begin
        wState <= devIdle;
      end
    end
  end

  // read sees the old word on a same-cycle collision
  always_ff @(posedge clk) begin
    if (wAccept) begin
      for (int i = 0; i < $bits(strbT); i++) begin
        if (wstrb_i[i]) begin
          mem[wIndex][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
    if (rAccept) begin
      rdata_o <= mem[rIndex];
    end
  end

endmodule

//--- logic/busFabric.sv
`timescale 1ns/1ps

module busFabric (
  input  logic          clk,
  input  logic          rst,
  input  logic          arvalidA_i,
  input  busPkg::addrT  araddrA_i,
  input  logic          rreadyA_i,
  output logic          arreadyA_o,
  output logic          rvalidA_o,
  output busPkg::dataT  rdataA_o,
  output busPkg::respT  rrespA_o,
  input  logic          awvalidA_i,
  input  busPkg::addrT  awaddrA_i,
  input  logic          wvalidA_i,
  input  busPkg::dataT  wdataA_i,
  input  busPkg::strbT  wstrbA_i,
  input  logic          breadyA_i,
  output logic          awreadyA_o,
  output logic          wreadyA_o,
  output logic          bvalidA_o,
  output busPkg::respT  brespA_o,
  input  logic          arvalidB_i,
  input  busPkg::addrT  araddrB_i,
  input  logic          rreadyB_i,
  output logic          arreadyB_o,
  output logic          rvalidB_o,
  output busPkg::dataT  rdataB_o,
  output busPkg::respT  rrespB_o,
  input  logic          awvalidB_i,
  input  busPkg::addrT  awaddrB_i,
  input  logic          wvalidB_i,
  input  busPkg::dataT  wdataB_i,
  input  busPkg::strbT  wstrbB_i,
  input  logic          breadyB_i,
  output logic          awreadyB_o,
  output logic          wreadyB_o,
  output logic          bvalidB_o,
  output busPkg::respT  brespB_o,
  output logic [7:0]    txByte_o,
  output logic          txValid_o
);
  import busPkg::*;

  // uart side
  logic uartArvalid, uartArready, uartRready, uartRvalid;
  logic uartAwvalid, uartAwready, uartWvalid, uartWready;
  logic uartBready, uartBvalid;
  addrT uartAraddr, uartAwaddr;
  dataT uartRdata, uartWdata;
  strbT uartWstrb;
  respT uartRresp, uartBresp;

  // sram side
  logic sramArvalid, sramArready, sramRready, sramRvalid;
  logic sramAwvalid, sramAwready, sramWvalid, sramWready;
  logic sramBready, sramBvalid;
  addrT sramAraddr, sramAwaddr;
  dataT sramRdata, sramWdata;
  strbT sramWstrb;
  respT sramRresp, sramBresp;

  // master ports share names with the top, so .* picks them up
  readRouter rdRouter (
    .uartArready_i(uartArready),
    .uartRvalid_i (uartRvalid),
    .uartRdata_i  (uartRdata),
    .uartRresp_i  (uartRresp),
    .sramArready_i(sramArready),
    .sramRvalid_i (sramRvalid),
    .sramRdata_i  (sramRdata),
    .sramRresp_i  (sramRresp),
    .uartArvalid_o(uartArvalid),
    .uartAraddr_o (uartAraddr),
    .uartRready_o (uartRready),
    .sramArvalid_o(sramArvalid),
    .sramAraddr_o (sramAraddr),
    .sramRready_o (sramRready),
    .*
  );

  writeRouter wrRouter (
    .uartAwready_i(uartAwready),
    .uartWready_i (uartWready),
    .uartBvalid_i (uartBvalid),
    .uartBresp_i  (uartBresp),
    .sramAwready_i(sramAwready),
    .sramWready_i (sramWready),
    .sramBvalid_i (sramBvalid),
    .sramBresp_i  (sramBresp),
    .uartAwvalid_o(uartAwvalid),
    .uartAwaddr_o (uartAwaddr),
    .uartWvalid_o (uartWvalid),
    .uartWdata_o  (uartWdata),
    .uartWstrb_o  (uartWstrb),
    .uartBready_o (uartBready),
    .sramAwvalid_o(sramAwvalid),
    .sramAwaddr_o (sramAwaddr),
    .sramWvalid_o (sramWvalid),
    .sramWdata_o  (sramWdata),
    .sramWstrb_o  (sramWstrb),
    .sramBready_o (sramBready),
    .*
  );

  uartDevice uart (
    .clk,
    .rst,
    .arvalid_i(uartArvalid),
    .araddr_i (uartAraddr),
    .rready_i (uartRready),
    .awvalid_i(uartAwvalid),
    .awaddr_i (uartAwaddr),
    .wvalid_i (uartWvalid),
    .wdata_i  (uartWdata),
    .wstrb_i  (uartWstrb),
    .bready_i (uartBready),
    .arready_o(uartArready),
    .rvalid_o (uartRvalid),
    .rdata_o  (uartRdata),
    .rresp_o  (uartRresp),
    .awready_o(uartAwready),
    .wready_o (uartWready),
    .bvalid_o (uartBvalid),
    .bresp_o  (uartBresp),
    .txByte_o,
    .txValid_o
  );

  sramDevice sram (
    .clk,
    .rst,
    .arvalid_i(sramArvalid),
    .araddr_i (sramAraddr),
    .rready_i (sramRready),
    .awvalid_i(sramAwvalid),
    .awaddr_i (sramAwaddr),
    .wvalid_i (sramWvalid),
    .wdata_i  (sramWdata),
    .wstrb_i  (sramWstrb),
    .bready_i (sramBready),
    .arready_o(sramArready),
    .rvalid_o (sramRvalid),
    .rdata_o  (sramRdata),
    .rresp_o  (sramRresp),
    .awready_o(sramAwready),
    .wready_o (sramWready),
    .bvalid_o (sramBvalid),
    .bresp_o  (sramBresp)
  );

endmodule

//--- tests/busFabric_assert.sv
`timescale 1ns/1ps

module busFabricAssert (
  input logic clk,
  input logic rst,
  input logic rvalidA_i,
  input logic rvalidB_i,
  input logic rreadyA_i,
  input logic rreadyB_i,
  input logic bvalidA_i,
  input logic bvalidB_i,
  input logic txValid_i
);

  // one owner per router
  rvalidExclusive: assert property (@(posedge clk) disable iff (rst)
    !(rvalidA_i && rvalidB_i))
    else $error("rvalid high to both masters");

  bvalidExclusive: assert property (@(posedge clk) disable iff (rst)
    !(bvalidA_i && bvalidB_i))
    else $error("bvalid high to both masters");

  rvalidAHeld: assert property (@(posedge clk) disable iff (rst)
    rvalidA_i && !rreadyA_i |=> rvalidA_i)
    else $error("rvalid to master A dropped before rready");

  rvalidBHeld: assert property (@(posedge clk) disable iff (rst)
    rvalidB_i && !rreadyB_i |=> rvalidB_i)
    else $error("rvalid to master B dropped before rready");

  txQuietInReset: assert property (@(posedge clk) rst |=> !txValid_i)
    else $error("txValid high during reset");

endmodule

bind busFabric busFabricAssert handshakeChecks (
  .clk      (clk),
  .rst      (rst),
  .rvalidA_i(rvalidA_o),
  .rvalidB_i(rvalidB_o),
  .rreadyA_i(rreadyA_i),
  .rreadyB_i(rreadyB_i),
  .bvalidA_i(bvalidA_o),
  .bvalidB_i(bvalidB_o),
  .txValid_i(txValid_o)
);

//--- tests/busFabricTb.sv
`timescale 1ns/1ps

module busFabricTb;
  import busPkg::*;

  typedef struct packed {
    logic [63:0] cmd;
    logic [63:0] who;
    addrT        addr;
    dataT        data;
    strbT        strb;
    dataT        expv;
  } txnT;

  localparam logic [63:0] cmdRead     = 64'("read");
  localparam logic [63:0] cmdWrite    = 64'("write");
  localparam logic [63:0] cmdPaired   = 64'("paired");
  localparam logic [63:0] whoB        = 64'("B");
  localparam logic [63:0] pairRd      = 64'("rd");
  localparam logic [63:0] pairWr      = 64'("wr");
  localparam logic [63:0] commentMark = 64'("#");

  logic             clk;
  logic             rst;
  // index 0 is master A and index 1 is master B
  logic [1:0]       arvalid;
  logic [1:0][31:0] araddr;
  logic [1:0]       rready;
  logic [1:0]       awvalid;
  logic [1:0][31:0] awaddr;
  logic [1:0]       wvalid;
  logic [1:0][31:0] wdata;
  logic [1:0][3:0]  wstrb;
  logic [1:0]       bready;
  wire  [1:0]       arready;
  wire  [1:0]       rvalid;
  wire  [1:0][31:0] rdata;
  wire  [1:0][1:0]  rresp;
  wire  [1:0]       awready;
  wire  [1:0]       wready;
  wire  [1:0]       bvalid;
  wire  [1:0][1:0]  bresp;
  wire  [7:0]       txByte;
  wire              txValid;

  txnT    txns[$];
  integer seed;
  int     limitCycles = 0;
  int     seenTx = 0;
  int     expTxCount = 0;
  time    doneAt[2];

  busFabric uut (
    .clk       (clk),
    .rst       (rst),
    .arvalidA_i(arvalid[0]),
    .araddrA_i (araddr[0]),
    .rreadyA_i (rready[0]),
    .arreadyA_o(arready[0]),
    .rvalidA_o (rvalid[0]),
    .rdataA_o  (rdata[0]),
    .rrespA_o  (rresp[0]),
    .awvalidA_i(awvalid[0]),
    .awaddrA_i (awaddr[0]),
    .wvalidA_i (wvalid[0]),
    .wdataA_i  (wdata[0]),
    .wstrbA_i  (wstrb[0]),
    .breadyA_i (bready[0]),
    .awreadyA_o(awready[0]),
    .wreadyA_o (wready[0]),
    .bvalidA_o (bvalid[0]),
    .brespA_o  (bresp[0]),
    .arvalidB_i(arvalid[1]),
    .araddrB_i (araddr[1]),
    .rreadyB_i (rready[1]),
    .arreadyB_o(arready[1]),
    .rvalidB_o (rvalid[1]),
    .rdataB_o  (rdata[1]),
    .rrespB_o  (rresp[1]),
    .awvalidB_i(awvalid[1]),
    .awaddrB_i (awaddr[1]),
    .wvalidB_i (wvalid[1]),
    .wdataB_i  (wdata[1]),
    .wstrbB_i  (wstrb[1]),
    .breadyB_i (bready[1]),
    .awreadyB_o(awready[1]),
    .wreadyB_o (wready[1]),
    .bvalidB_o (bvalid[1]),
    .brespB_o  (bresp[1]),
    .txByte_o  (txByte),
    .txValid_o (txValid)
  );

  always #20 clk = ~clk;

  // count tx strobes on the output for the final check
  always @(negedge clk) begin
    if (!rst && txValid) begin
      seenTx = seenTx + 1;
    end
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
    if (got !== expected) begin
      abortRun($sformatf("MISMATCH at %0d ns: %s, got %h, expected %h",
                         $time, what, got, expected));
    end
  endtask

  task automatic loadStimulus();
    int          fd;
    int          n;
    int          c;
    txnT         t;
    logic [63:0] tok;
    logic [63:0] who;
    dataT        addrV;
    dataT        dataV;
    dataT        strbV;
    dataT        expV;
    fd = $fopen("tests/busFabric_input.txt", "r");
    if (fd == 0) begin
      abortRun("could not open the stimulus file tests/busFabric_input.txt");
    end
    tok = '0;
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == commentMark) begin
        // skip the rest of a column header
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
      end else begin
        who = '0;
        n = $fscanf(fd, "%s %h %h %h %h", who, addrV, dataV, strbV, expV);
        if (n != 5) begin
          abortRun("a line of the stimulus file has too few columns");
        end
        if (tok != cmdRead && tok != cmdWrite && tok != cmdPaired) begin
          abortRun("the stimulus file holds an unknown command");
        end
        t.cmd  = tok;
        t.who  = who;
        t.addr = addrV;
        t.data = dataV;
        t.strb = strbV[3:0];
        t.expv = expV;
        txns.push_back(t);
      end
      tok = '0;
    end
    $fclose(fd);
  endtask

  task automatic doRead(input int m, input addrT addr, input dataT expData);
    int delay;
    @(posedge clk);
    arvalid[m] <= 1'b1;
    araddr[m]  <= addr;
    @(negedge clk);
    while (!arready[m]) begin
      @(negedge clk);
    end
    @(posedge clk);
    arvalid[m] <= 1'b0;
    @(negedge clk);
    checkValue(32'(rvalid[m]), 32'd1, "rvalid one cycle after address handshake");
    checkValue(rdata[m], expData, "read data");
    checkValue(32'(rresp[m]), 32'(respOkay), "read response");
    delay = {$random(seed)} % 4;
    repeat (delay) begin
      @(negedge clk);
      checkValue(32'(rvalid[m]), 32'd1, "rvalid held under back-pressure");
      checkValue(rdata[m], expData, "rdata held under back-pressure");
    end
    @(posedge clk);
    rready[m] <= 1'b1;
    @(posedge clk);
    rready[m] <= 1'b0;
    doneAt[m] = $time;
  endtask

  task automatic doWrite(input int m, input addrT addr, input dataT data, input strbT strb,
                         input logic [7:0] expByte);
    int   delay;
    logic pulse;
    // only the UART address with lane 0 enabled sends a byte
    pulse = (addr == uartAddr) && strb[0];
    @(posedge clk);
    awvalid[m] <= 1'b1;
    awaddr[m]  <= addr;
    wvalid[m]  <= 1'b1;
    wdata[m]   <= data;
    wstrb[m]   <= strb;
    @(negedge clk);
    while (!(awready[m] && wready[m])) begin
      @(negedge clk);
    end
    @(posedge clk);
    awvalid[m] <= 1'b0;
    wvalid[m]  <= 1'b0;
    @(negedge clk);
    checkValue(32'(bvalid[m]), 32'd1, "bvalid one cycle after acceptance");
    checkValue(32'(bresp[m]), 32'(respOkay), "write response");
    checkValue(32'(txValid), 32'(pulse), "tx strobe alongside bvalid");
    if (pulse) begin
      checkValue({24'd0, txByte}, {24'd0, expByte}, "tx byte");
      expTxCount++;
    end
    delay = {$random(seed)} % 4;
    repeat (delay) begin
      @(negedge clk);
      checkValue(32'(bvalid[m]), 32'd1, "bvalid held under back-pressure");
    end
    @(posedge clk);
    bready[m] <= 1'b1;
    @(posedge clk);
    bready[m] <= 1'b0;
    doneAt[m] = $time;
  endtask

  task automatic runTxn(input txnT t);
    int m;
    m = (t.who == whoB) ? 1 : 0;
    if (t.cmd == cmdRead) begin
      doRead(m, t.addr, t.expv);
    end else if (t.cmd == cmdWrite) begin
      doWrite(m, t.addr, t.data, t.strb, t.expv[7:0]);
    end else if (t.who == pairRd) begin
      fork
        doRead(0, t.addr, t.expv);
        doRead(1, t.addr, t.expv);
      join
      checkValue(32'(doneAt[0] < doneAt[1]), 32'd1, "master A served before master B");
    end else if (t.who == pairWr) begin
      fork
        doWrite(0, t.addr, t.data, t.strb, t.data[7:0]);
        doWrite(1, t.addr, t.expv, t.strb, t.expv[7:0]);
      join
      checkValue(32'(doneAt[0] < doneAt[1]), 32'd1, "master A served before master B");
    end else begin
      // A reads the word that B overwrites in the same cycle
      fork
        doRead(0, t.addr, t.expv);
        doWrite(1, t.addr, t.data, t.strb, t.data[7:0]);
      join
    end
  endtask

  // watchdog scaled to the number of transactions
  initial begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge clk);
    abortRun($sformatf("timeout: the bench did not finish within %0d cycles", limitCycles));
  end

  initial begin
    clk = 1'b0;
    rst <= 1'b1;
    arvalid <= '0;
    araddr <= '0;
    rready <= '0;
    awvalid <= '0;
    awaddr <= '0;
    wvalid <= '0;
    wdata <= '0;
    wstrb <= '0;
    bready <= '0;
    seed = 32'h6e37_a17b;
    loadStimulus();
    limitCycles = txns.size() * 20 + 50;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkValue(32'(rvalid), 32'd0, "rvalid low after reset");
    checkValue(32'(bvalid), 32'd0, "bvalid low after reset");
    checkValue(32'(txValid), 32'd0, "txValid low after reset");
    foreach (txns[i]) begin
      runTxn(txns[i]);
    end
    repeat (2) @(posedge clk);
    checkValue(seenTx, expTxCount, "number of tx strobes");
    $display("test passed");
    $finish;
  end

endmodule

//--- tests/busFabric_input.txt
# cmd    who  addr      data      strb  expect    (who for paired: rd, wr or rw)
# expect is read data, tx byte for writes, or master B's word for paired wr
write  A   00000010  11223344  f  00000000
read   A   00000010  00000000  0  11223344
write  B   00000010  aabbccdd  1  00000000
read   B   00000010  00000000  0  112233dd
write  B   00000010  99887766  6  00000000
read   A   00000010  00000000  0  118877dd
write  B   00000010  55555555  8  00000000
read   A   00000010  00000000  0  558877dd
read   B   00000410  00000000  0  558877dd
read   A   10000000  00000000  0  00000000
write  A   10000000  00000041  1  00000041
write  B   10000000  00000042  e  00000000
write  B   10000000  12345643  f  00000043
read   B   10000000  00000000  0  00000002
paired rd  00000010  00000000  0  558877dd
paired wr  00000020  cafef00d  f  0badbeef
read   A   00000020  00000000  0  0badbeef
paired wr  10000000  00000061  1  00000062
paired rd  10000000  00000000  0  00000004
paired rw  00000020  5a5a5a5a  3  0badbeef
read   B   00000020  00000000  0  0bad5a5a
write  A   00000030  01020304  f  00000000
paired rw  00000030  f0f0f0f0  c  01020304
read   A   00000030  00000000  0  f0f00304

//--- sources.f
logic/busPkg.sv
logic/readRouter.sv
logic/writeRouter.sv
logic/uartDevice.sv
logic/sramDevice.sv
logic/busFabric.sv
tests/busFabric_assert.sv
tests/busFabricTb.sv

//--- run.sh
#!/bin/sh
# build and run the bus fabric testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module busFabricTb -f sources.f -o busFabricSim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/busFabricSim > "$log" 2>&1
simStatus=$?
cat "$log"

if grep -q "test failed" "$log"; then
  echo "FAIL: see $log"
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "FAIL: simulation exited with status $simStatus"
  exit 1
fi
echo "PASS"
exit 0
